//--- design/lsys_pkg.sv
package lsys_pkg;

	////////////////////
	// Symbol alphabet
	////////////////////

	typedef logic [7:0] symbol_t;

	// ASCII codes of the symbols the rule sets know
	localparam symbol_t SYM_F     = 8'd70;
	localparam symbol_t SYM_A     = 8'd65;
	localparam symbol_t SYM_X     = 8'd88;
	localparam symbol_t SYM_Y     = 8'd89;
	localparam symbol_t SYM_PLUS  = 8'd43;
	localparam symbol_t SYM_MINUS = 8'd45;

	// Seven rule sets and a plain copy as the last selector
	typedef enum logic [2:0] {
		DRAGON     = 3'd0,
		ARROW_XY   = 3'd1,
		KOCH       = 3'd2,
		ARROW_AF   = 3'd3,
		SNOWFLAKE  = 3'd4,
		CROSS      = 3'd5,
		TESSELLATE = 3'd6,
		IDENTITY   = 3'd7
	} lsystem_e;

	////////////////////
	// Sizes
	////////////////////

	localparam int MAX_EXPANSION = 10;
	localparam int LEN_W         = 4;
	localparam int ITER_W        = 4;
	localparam int AXIOM_LEN     = 4;

	// One production with its first symbol in the top byte
	typedef struct packed {
		logic [LEN_W-1:0]              len;
		symbol_t [MAX_EXPANSION-1:0]   syms;
	} expansion_t;

	// One symbol on the output stream
	typedef struct packed {
		symbol_t           sym;
		logic [ITER_W-1:0] gen;
		logic              last;
	} stream_item_t;

endpackage

//--- design/lsys_top.sv
`timescale 1ns/1ns

module lsys_top #(
	parameter int ADDR_W = 10
) (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             start,
	input  lsys_pkg::lsystem_e               lsystem,
	input  logic [8*lsys_pkg::AXIOM_LEN-1:0] axiom,
	input  logic [lsys_pkg::ITER_W-1:0]      iterations,
	input  logic                             out_ready,
	output logic                             out_valid,
	output lsys_pkg::stream_item_t           out_item,
	output logic                             busy,
	output logic                             done,
	output logic                             overflow
);

	lsys_pkg::expansion_t   exp;
	lsys_pkg::symbol_t      lookup_sym;
	lsys_pkg::lsystem_e     lsystem_q;
	lsys_pkg::symbol_t      wr_sym;
	lsys_pkg::symbol_t      rd_sym;
	lsys_pkg::stream_item_t push_item;
	logic                   lookup_valid;
	logic                   wr_en;
	logic                   wr_bank;
	logic [ADDR_W-1:0]      wr_addr;
	logic                   rd_bank;
	logic [ADDR_W-1:0]      rd_addr;
	logic                   push;
	logic                   full;
	logic                   empty;

	rule_decode u_decode (
		.clk          (clk),
		.reset        (reset),
		.lsystem      (lsystem_q),
		.lookup_valid (lookup_valid),
		.lookup_sym   (lookup_sym),
		.exp          (exp)
	);

	symbol_buffer #(.ADDR_W(ADDR_W)) u_buffer (
		.clk     (clk),
		.wr_en   (wr_en),
		.wr_bank (wr_bank),
		.wr_addr (wr_addr),
		.wr_sym  (wr_sym),
		.rd_bank (rd_bank),
		.rd_addr (rd_addr),
		.rd_sym  (rd_sym)
	);

	rewrite_engine #(.ADDR_W(ADDR_W)) u_engine (
		.clk          (clk),
		.reset        (reset),
		.start        (start),
		.lsystem      (lsystem),
		.axiom        (axiom),
		.iterations   (iterations),
		.exp          (exp),
		.lookup_valid (lookup_valid),
		.lookup_sym   (lookup_sym),
		.lsystem_q    (lsystem_q),
		.wr_en        (wr_en),
		.wr_bank      (wr_bank),
		.wr_addr      (wr_addr),
		.wr_sym       (wr_sym),
		.rd_bank      (rd_bank),
		.rd_addr      (rd_addr),
		.rd_sym       (rd_sym),
		.push         (push),
		.push_item    (push_item),
		.full         (full),
		.empty        (empty),
		.busy         (busy),
		.done         (done),
		.overflow     (overflow)
	);

	symbol_stream u_stream (
		.clk       (clk),
		.reset     (reset),
		.push      (push),
		.push_item (push_item),
		.full      (full),
		.empty     (empty),
		.out_ready (out_ready),
		.out_valid (out_valid),
		.out_item  (out_item)
	);

endmodule

//--- design/rewrite_engine.sv
`timescale 1ns/1ns

module rewrite_engine #(
	parameter int ADDR_W = 10
) (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 start,
	input  lsys_pkg::lsystem_e                   lsystem,
	input  logic [8*lsys_pkg::AXIOM_LEN-1:0]     axiom,
	input  logic [lsys_pkg::ITER_W-1:0]          iterations,
	input  lsys_pkg::expansion_t                 exp,
	output logic                                 lookup_valid,
	output lsys_pkg::symbol_t                    lookup_sym,
	output lsys_pkg::lsystem_e                   lsystem_q,
	output logic                                 wr_en,
	output logic                                 wr_bank,
	output logic [ADDR_W-1:0]                    wr_addr,
	output lsys_pkg::symbol_t                    wr_sym,
	output logic                                 rd_bank,
	output logic [ADDR_W-1:0]                    rd_addr,
	input  lsys_pkg::symbol_t                    rd_sym,
	output logic                                 push,
	output lsys_pkg::stream_item_t               push_item,
	input  logic                                 full,
	input  logic                                 empty,
	output logic                                 busy,
	output logic                                 done,
	output logic                                 overflow
);

	typedef logic [ADDR_W:0] count_t;
	typedef logic [lsys_pkg::ITER_W-1:0] gen_t;
	typedef logic [lsys_pkg::LEN_W-1:0] idx_t;

	typedef enum logic [2:0] {
		S_IDLE,
		S_FETCH,
		S_LOOKUP,
		S_EMIT,
		S_NEXT_GEN,
		S_FINISH
	} state_e;

	state_e state;

	// Symbol counts of the generation being read and the one being written
	count_t src_len;
	count_t src_idx;
	count_t dst_len;

	gen_t gen_q;
	gen_t iter_q;
	idx_t exp_idx;
	idx_t sym_sel;
	logic [8*lsys_pkg::AXIOM_LEN-1:0] axiom_q;
	lsys_pkg::symbol_t cur_sym;
	logic capped;
	logic exp_end;
	logic advance;

	// Axiom ends at its first zero byte
	function automatic count_t axiom_length(input logic [8*lsys_pkg::AXIOM_LEN-1:0] a);
		count_t n;
		logic stop;
		n = '0;
		stop = 1'b0;
		for (int i = 0; i < lsys_pkg::AXIOM_LEN; i++) begin
			if (!stop && a[8*i +: 8] != 8'd0)
				n = n + count_t'(1);
			else
				stop = 1'b1;
		end
		return n;
	endfunction

	////////////////////
	// Datapath taps
	////////////////////

	// Top bit set means the destination bank is full
	assign capped  = dst_len[ADDR_W];
	assign sym_sel = idx_t'(lsys_pkg::MAX_EXPANSION - 1) - exp_idx;
	assign cur_sym = exp.syms[sym_sel];
	assign exp_end = (exp_idx == exp.len - idx_t'(1));
	assign advance = (state == S_EMIT) && !capped && !full;

	assign lookup_valid = (state == S_LOOKUP);
	// Generation 1 expands the axiom, later ones the previous bank
	assign lookup_sym   = (gen_q == gen_t'(1)) ? axiom_q[7:0] : rd_sym;

	assign rd_bank = ~gen_q[0];
	assign rd_addr = src_idx[ADDR_W-1:0];
	assign wr_bank = gen_q[0];
	assign wr_addr = dst_len[ADDR_W-1:0];
	assign wr_sym  = cur_sym;
	assign wr_en   = advance;

	assign push           = advance;
	assign push_item.sym  = cur_sym;
	assign push_item.gen  = gen_q;
	// Final symbol is either the natural end or the one that fills the bank
	assign push_item.last = (gen_q == iter_q) &&
		((exp_end && src_idx == src_len) || dst_len == count_t'(2 ** ADDR_W - 1));

	assign busy = (state != S_IDLE);
	assign done = (state == S_FINISH) && empty;

	////////////////////
	// Control FSM
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= S_IDLE;
			overflow <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (start) begin
						overflow <= 1'b0;
						state    <= (iterations == '0) ? S_FINISH : S_FETCH;
					end
				end
				S_FETCH:
					state <= (src_idx == src_len) ? S_NEXT_GEN : S_LOOKUP;
				S_LOOKUP:
					state <= S_EMIT;
				S_EMIT: begin
					// Everything after the cap is dropped, so skip the rest
					if (capped) begin
						overflow <= 1'b1;
						state    <= S_NEXT_GEN;
					end else if (!full && exp_end) begin
						state <= S_FETCH;
					end
				end
				S_NEXT_GEN:
					state <= (gen_q == iter_q) ? S_FINISH : S_FETCH;
				S_FINISH: begin
					// Wait for the queue to drain before signalling done
					if (empty)
						state <= S_IDLE;
				end
				default:
					state <= S_IDLE;
			endcase
		end
	end

	// Counters and latched job
	always_ff @(posedge clk) begin
		case (state)
			S_IDLE: begin
				if (start) begin
					lsystem_q <= lsystem;
					axiom_q   <= axiom;
					iter_q    <= iterations;
					gen_q     <= gen_t'(1);
					src_len   <= axiom_length(axiom);
					src_idx   <= '0;
					dst_len   <= '0;
				end
			end
			S_FETCH: begin
				if (src_idx != src_len)
					src_idx <= src_idx + count_t'(1);
			end
			S_LOOKUP: begin
				exp_idx <= '0;
				if (gen_q == gen_t'(1))
					axiom_q <= axiom_q >> 8;
			end
			S_EMIT: begin
				if (advance) begin
					dst_len <= dst_len + count_t'(1);
					exp_idx <= exp_idx + idx_t'(1);
				end
			end
			S_NEXT_GEN: begin
				if (gen_q != iter_q) begin
					gen_q   <= gen_q + gen_t'(1);
					src_len <= dst_len;
					src_idx <= '0;
					dst_len <= '0;
				end
			end
			default: ;
		endcase
	end

endmodule

//--- design/rule_decode.sv
`timescale 1ns/1ns

module rule_decode (
	input  logic                 clk,
	input  logic                 reset,
	input  lsys_pkg::lsystem_e   lsystem,
	input  logic                 lookup_valid,
	input  lsys_pkg::symbol_t    lookup_sym,
	output lsys_pkg::expansion_t exp
);

	lsys_pkg::expansion_t nxt;

	// Builds one expansion from a length and a left-aligned symbol string
	function automatic lsys_pkg::expansion_t prod(
		input logic [lsys_pkg::LEN_W-1:0]           len,
		input logic [8*lsys_pkg::MAX_EXPANSION-1:0] syms
	);
		lsys_pkg::expansion_t e;
		e.len  = len;
		e.syms = syms;
		return e;
	endfunction

	////////////////////
	// Production table
	////////////////////

	always_comb begin
		// Unmatched symbols copy through
		nxt = prod(4'd1, {lookup_sym, 72'd0});
		case (lsystem)
			lsys_pkg::DRAGON: begin
				if (lookup_sym == lsys_pkg::SYM_X)
					nxt = prod(4'd5, {lsys_pkg::SYM_X, lsys_pkg::SYM_PLUS, lsys_pkg::SYM_Y,
						lsys_pkg::SYM_F, lsys_pkg::SYM_PLUS, 40'd0});
				else if (lookup_sym == lsys_pkg::SYM_Y)
					nxt = prod(4'd5, {lsys_pkg::SYM_MINUS, lsys_pkg::SYM_F, lsys_pkg::SYM_X,
						lsys_pkg::SYM_MINUS, lsys_pkg::SYM_Y, 40'd0});
			end
			lsys_pkg::ARROW_XY: begin
				if (lookup_sym == lsys_pkg::SYM_X)
					nxt = prod(4'd7, {lsys_pkg::SYM_Y, lsys_pkg::SYM_F, lsys_pkg::SYM_PLUS,
						lsys_pkg::SYM_X, lsys_pkg::SYM_F, lsys_pkg::SYM_PLUS,
						lsys_pkg::SYM_Y, 24'd0});
				else if (lookup_sym == lsys_pkg::SYM_Y)
					nxt = prod(4'd7, {lsys_pkg::SYM_X, lsys_pkg::SYM_F, lsys_pkg::SYM_MINUS,
						lsys_pkg::SYM_Y, lsys_pkg::SYM_F, lsys_pkg::SYM_MINUS,
						lsys_pkg::SYM_X, 24'd0});
			end
			lsys_pkg::KOCH: begin
				if (lookup_sym == lsys_pkg::SYM_F)
					nxt = prod(4'd8, {lsys_pkg::SYM_F, lsys_pkg::SYM_PLUS, lsys_pkg::SYM_F,
						lsys_pkg::SYM_MINUS, lsys_pkg::SYM_MINUS, lsys_pkg::SYM_F,
						lsys_pkg::SYM_PLUS, lsys_pkg::SYM_F, 16'd0});
			end
			lsys_pkg::ARROW_AF: begin
				if (lookup_sym == lsys_pkg::SYM_A)
					nxt = prod(4'd7, {lsys_pkg::SYM_PLUS, lsys_pkg::SYM_F, lsys_pkg::SYM_MINUS,
						lsys_pkg::SYM_A, lsys_pkg::SYM_MINUS, lsys_pkg::SYM_F,
						lsys_pkg::SYM_PLUS, 24'd0});
				else if (lookup_sym == lsys_pkg::SYM_F)
					nxt = prod(4'd7, {lsys_pkg::SYM_MINUS, lsys_pkg::SYM_A, lsys_pkg::SYM_PLUS,
						lsys_pkg::SYM_F, lsys_pkg::SYM_PLUS, lsys_pkg::SYM_A,
						lsys_pkg::SYM_MINUS, 24'd0});
			end
			lsys_pkg::SNOWFLAKE: begin
				if (lookup_sym == lsys_pkg::SYM_F)
					nxt = prod(4'd8, {lsys_pkg::SYM_F, lsys_pkg::SYM_MINUS, lsys_pkg::SYM_F,
						lsys_pkg::SYM_PLUS, lsys_pkg::SYM_PLUS, lsys_pkg::SYM_F,
						lsys_pkg::SYM_MINUS, lsys_pkg::SYM_F, 16'd0});
			end
			lsys_pkg::CROSS: begin
				if (lookup_sym == lsys_pkg::SYM_F)
					nxt = prod(4'd9, {lsys_pkg::SYM_F, lsys_pkg::SYM_PLUS, lsys_pkg::SYM_F,
						lsys_pkg::SYM_F, lsys_pkg::SYM_PLUS, lsys_pkg::SYM_PLUS,
						lsys_pkg::SYM_F, lsys_pkg::SYM_PLUS, lsys_pkg::SYM_F, 8'd0});
			end
			lsys_pkg::TESSELLATE: begin
				if (lookup_sym == lsys_pkg::SYM_F)
					nxt = prod(4'd5, {lsys_pkg::SYM_F, lsys_pkg::SYM_MINUS, lsys_pkg::SYM_F,
						lsys_pkg::SYM_PLUS, lsys_pkg::SYM_F, 40'd0});
			end
			default: ;
		endcase
	end

	// Result holds until the next lookup
	always_ff @(posedge clk) begin
		if (reset)
			exp <= '0;
		else if (lookup_valid)
			exp <= nxt;
	end

endmodule

//--- design/symbol_buffer.sv
`timescale 1ns/1ns

module symbol_buffer #(
	parameter int ADDR_W = 10
) (
	input  logic              clk,
	input  logic              wr_en,
	input  logic              wr_bank,
	input  logic [ADDR_W-1:0] wr_addr,
	input  lsys_pkg::symbol_t wr_sym,
	input  logic              rd_bank,
	input  logic [ADDR_W-1:0] rd_addr,
	output lsys_pkg::symbol_t rd_sym
);

	localparam int DEPTH = 2 ** ADDR_W;

	// Ping-pong banks with one generation each
	lsys_pkg::symbol_t bank0 [DEPTH];
	lsys_pkg::symbol_t bank1 [DEPTH];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			if (wr_bank)
				bank1[wr_addr] <= wr_sym;
			else
				bank0[wr_addr] <= wr_sym;
		end
	end

	// Read data arrives one cycle after the address
	always_ff @(posedge clk) begin
		if (rd_bank)
			rd_sym <= bank1[rd_addr];
		else
			rd_sym <= bank0[rd_addr];
	end

endmodule

//--- design/symbol_stream.sv
`timescale 1ns/1ns

module symbol_stream (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   push,
	input  lsys_pkg::stream_item_t push_item,
	output logic                   full,
	output logic                   empty,
	input  logic                   out_ready,
	output logic                   out_valid,
	output lsys_pkg::stream_item_t out_item
);

	lsys_pkg::stream_item_t entries [2];
	logic       wr_ptr;
	logic       rd_ptr;
	logic [1:0] count;
	logic       do_push;
	logic       do_pop;

	assign full      = (count == 2'd2);
	assign empty     = (count == 2'd0);
	assign out_valid = !empty;
	// Head entry stays put until it is taken
	assign out_item  = entries[rd_ptr];

	assign do_push = push && !full;
	assign do_pop  = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count  <= 2'd0;
		end else begin
			if (do_push)
				wr_ptr <= ~wr_ptr;
			if (do_pop)
				rd_ptr <= ~rd_ptr;
			if (do_push && !do_pop)
				count <= count + 2'd1;
			else if (do_pop && !do_push)
				count <= count - 2'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			entries[wr_ptr] <= push_item;
	end

endmodule

//--- lsys_top.f
design/lsys_pkg.sv
design/rule_decode.sv
design/symbol_buffer.sv
design/rewrite_engine.sv
design/symbol_stream.sv
design/lsys_top.sv
tb/lsys_chk.sv
tb/lsys_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module lsys_tb -f lsys_top.f -o lsys_sim

./obj_dir/lsys_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "=== PASS ===" sim.log; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation failed"
exit 1

//--- tb/lsys_chk.sv
`timescale 1ns/1ns

module lsys_chk (
	input logic                   clk,
	input logic                   reset,
	input logic                   out_valid,
	input logic                   out_ready,
	input lsys_pkg::stream_item_t out_item,
	input logic                   busy,
	input logic                   done,
	input logic                   overflow
);

	////////////////////
	// Output stream
	////////////////////

	// A stalled item holds until it is taken
	a_stall_holds: assert property (@(posedge clk) disable iff (reset)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_item)))
		else $error("out_item changed while out_valid was high and out_ready low");

	// Quiet during reset and in the first cycle after it
	a_quiet_reset: assert property (@(posedge clk) reset |=> !out_valid)
		else $error("out_valid high during or right after reset");

	////////////////////
	// Job status
	////////////////////

	// Done is a single cycle inside the job and ends it
	a_done_busy: assert property (@(posedge clk) disable iff (reset)
		done |-> busy ##1 (!busy && !done))
		else $error("done pulsed outside a job or the job went on after done");

	// Sticky for the whole job
	a_overflow_sticky: assert property (@(posedge clk) disable iff (reset)
		(busy && overflow) |=> overflow)
		else $error("overflow fell while a job was running");

endmodule

bind lsys_top lsys_chk u_chk (
	.clk       (clk),
	.reset     (reset),
	.out_valid (out_valid),
	.out_ready (out_ready),
	.out_item  (out_item),
	.busy      (busy),
	.done      (done),
	.overflow  (overflow)
);

//--- tb/lsys_tb.sv
`timescale 1ns/1ns

module lsys_tb;

	localparam int ADDR_W  = 6;
	localparam int CAP     = 2 ** ADDR_W;
	localparam int TIMEOUT = 5000;

	typedef logic [lsys_pkg::ITER_W-1:0] gen_t;

	logic                             clk;
	logic                             reset;
	logic                             start;
	lsys_pkg::lsystem_e               lsystem;
	logic [8*lsys_pkg::AXIOM_LEN-1:0] axiom;
	logic [lsys_pkg::ITER_W-1:0]      iterations;
	logic                             out_ready;
	logic                             out_valid;
	lsys_pkg::stream_item_t           out_item;
	logic                             busy;
	logic                             done;
	logic                             overflow;

	integer                 seed;
	lsys_pkg::stream_item_t exp_q [$];
	logic                   exp_ovf;

	lsys_top #(.ADDR_W(ADDR_W)) u_dut (
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.lsystem    (lsystem),
		.axiom      (axiom),
		.iterations (iterations),
		.out_ready  (out_ready),
		.out_valid  (out_valid),
		.out_item   (out_item),
		.busy       (busy),
		.done       (done),
		.overflow   (overflow)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////
	// String model
	////////////////////

	// Production of one symbol where unmatched symbols copy through
	function automatic string production(input lsys_pkg::lsystem_e ls,
		input lsys_pkg::symbol_t s);
		string r;
		r = $sformatf("%c", s);
		case (ls)
			lsys_pkg::DRAGON: begin
				if (s == "X")
					r = "X+YF+";
				else if (s == "Y")
					r = "-FX-Y";
			end
			lsys_pkg::ARROW_XY: begin
				if (s == "X")
					r = "YF+XF+Y";
				else if (s == "Y")
					r = "XF-YF-X";
			end
			lsys_pkg::KOCH:
				if (s == "F")
					r = "F+F--F+F";
			lsys_pkg::ARROW_AF: begin
				if (s == "A")
					r = "+F-A-F+";
				else if (s == "F")
					r = "-A+F+A-";
			end
			lsys_pkg::SNOWFLAKE:
				if (s == "F")
					r = "F-F++F-F";
			lsys_pkg::CROSS:
				if (s == "F")
					r = "F+FF++F+F";
			lsys_pkg::TESSELLATE:
				if (s == "F")
					r = "F-F+F";
			default: ;
		endcase
		return r;
	endfunction

	// Lowest byte holds the first axiom symbol
	function automatic logic [31:0] pack_axiom(input string ax);
		logic [31:0] a;
		a = '0;
		for (int i = 0; i < ax.len() && i < lsys_pkg::AXIOM_LEN; i++)
			a[8*i +: 8] = ax[i];
		return a;
	endfunction

	// Expected stream of every generation cut at the buffer size
	function automatic void build_model(input lsys_pkg::lsystem_e ls, input string ax,
		input int iters);
		lsys_pkg::symbol_t      cur [$];
		lsys_pkg::symbol_t      nxt [$];
		lsys_pkg::stream_item_t it;
		string                  r;
		exp_q.delete();
		exp_ovf = 1'b0;
		for (int i = 0; i < ax.len(); i++)
			cur.push_back(ax[i]);
		for (int g = 1; g <= iters; g++) begin
			nxt.delete();
			foreach (cur[i]) begin
				r = production(ls, cur[i]);
				for (int k = 0; k < r.len(); k++) begin
					if (nxt.size() < CAP)
						nxt.push_back(r[k]);
					else
						exp_ovf = 1'b1;
				end
			end
			foreach (nxt[i]) begin
				it.sym  = nxt[i];
				it.gen  = gen_t'(g);
				it.last = (g == iters) && (i == nxt.size() - 1);
				exp_q.push_back(it);
			end
			cur = nxt;
		end
	endfunction

	////////////////////
	// Checks
	////////////////////

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic value_error(input string name, input logic [31:0] e, input logic [31:0] a);
		stop_run($sformatf("** Error at %0t ns: %s expected 0x%0h, got 0x%0h",
			$time, name, e, a));
	endtask

	task automatic check_item();
		lsys_pkg::stream_item_t e;
		if (exp_q.size() == 0) begin
			stop_run("DUT streamed an item past the end of the expected stream");
		end else begin
			e = exp_q.pop_front();
			assert (out_item.sym == e.sym)
				else value_error("out_item.sym", 32'(e.sym), 32'(out_item.sym));
			assert (out_item.gen == e.gen)
				else value_error("out_item.gen", 32'(e.gen), 32'(out_item.gen));
			assert (out_item.last == e.last)
				else value_error("out_item.last", 32'(e.last), 32'(out_item.last));
		end
	endtask

	// One job from start to done with an optional extra start while busy
	task automatic run_job(input lsys_pkg::lsystem_e ls, input string ax, input int iters,
		input bit random_ready, input bit interrupt);
		int cycles;
		bit finished;
		build_model(ls, ax, iters);
		cycles   = 0;
		finished = 1'b0;
		@(posedge clk);
		start      <= 1'b1;
		lsystem    <= ls;
		axiom      <= pack_axiom(ax);
		iterations <= gen_t'(iters);
		out_ready  <= random_ready ? (($random(seed) & 3) != 0) : 1'b1;
		@(posedge clk);
		start <= 1'b0;
		@(negedge clk);
		assert (busy) else stop_run("busy did not rise after start was accepted");
		assert (!overflow) else value_error("overflow", 32'd0, 32'(overflow));
		while (!finished) begin
			if (out_valid && out_ready)
				check_item();
			if (done) begin
				finished = 1'b1;
			end else if (cycles == TIMEOUT) begin
				stop_run("timed out waiting for done");
			end else begin
				cycles++;
				@(posedge clk);
				out_ready <= random_ready ? (($random(seed) & 3) != 0) : 1'b1;
				if (interrupt && cycles == 6) begin
					start      <= 1'b1;
					lsystem    <= lsys_pkg::CROSS;
					axiom      <= pack_axiom("FF");
					iterations <= gen_t'(5);
				end else begin
					start <= 1'b0;
				end
				@(negedge clk);
			end
		end
		assert (exp_q.size() == 0)
			else stop_run($sformatf("done came with %0d expected items missing", exp_q.size()));
		assert (overflow == exp_ovf) else value_error("overflow", 32'(exp_ovf), 32'(overflow));
	endtask

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		seed       = 47372;
		reset      = 1'b1;
		start      = 1'b0;
		lsystem    = lsys_pkg::DRAGON;
		axiom      = '0;
		iterations = '0;
		out_ready  = 1'b1;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		assert (!out_valid) else value_error("out_valid", 32'd0, 32'(out_valid));
		assert (!busy) else value_error("busy", 32'd0, 32'(busy));
		assert (!done) else value_error("done", 32'd0, 32'(done));
		assert (!overflow) else value_error("overflow", 32'd0, 32'(overflow));

		// Zero iterations followed by full-rate and stalled streams
		run_job(lsys_pkg::DRAGON, "F", 0, 1'b0, 1'b0);
		run_job(lsys_pkg::DRAGON, "FX", 2, 1'b0, 1'b0);
		run_job(lsys_pkg::KOCH, "F", 2, 1'b1, 1'b0);
		// Third generation exceeds the 64 symbol bank
		run_job(lsys_pkg::KOCH, "F", 3, 1'b0, 1'b0);
		run_job(lsys_pkg::DRAGON, "FX", 3, 1'b1, 1'b1);

		run_job(lsys_pkg::ARROW_XY, "XF-Y", 1, 1'b0, 1'b0);
		run_job(lsys_pkg::ARROW_AF, "A-F+", 1, 1'b1, 1'b0);
		run_job(lsys_pkg::SNOWFLAKE, "F+XF", 1, 1'b0, 1'b0);
		run_job(lsys_pkg::CROSS, "F-YF", 1, 1'b1, 1'b0);
		run_job(lsys_pkg::TESSELLATE, "FA+F", 1, 1'b0, 1'b0);
		run_job(lsys_pkg::IDENTITY, "FXY+", 1, 1'b0, 1'b0);

		$display("=== PASS ===");
		$finish;
	end

endmodule
